//--- Bender.yml
package:
  name: r5p_mon

sources:
  - rtl/r5p_mon_pkg.sv
  - rtl/r5p_bus_mem.sv
  - rtl/r5p_bus_capture.sv
  - rtl/r5p_inst_decode.sv
  - rtl/r5p_bus_stats.sv
  - rtl/r5p_mon_top.sv
  - target: test
    files:
      - tests/r5p_mon_asserts.sv
      - tests/r5p_mon_tb.sv

//--- r5p_mon.f
rtl/r5p_mon_pkg.sv
rtl/r5p_bus_mem.sv
rtl/r5p_bus_capture.sv
rtl/r5p_inst_decode.sv
rtl/r5p_bus_stats.sv
rtl/r5p_mon_top.sv
tests/r5p_mon_asserts.sv
tests/r5p_mon_tb.sv

//--- rtl/r5p_bus_capture.sv
/*
  bus capture, one-cycle delayed copy of the system bus
  write-done, read-done and wait strobes
*/

`timescale 1ns/100ps

module r5p_bus_capture (
  // system
  input  logic                         clk,
  input  logic                         rst,
  // bus taps
  input  logic                         req,
  input  logic                         wen,
  input  logic [r5p_mon_pkg::AW-1:0]   adr,
  input  logic [r5p_mon_pkg::SW-1:0]   sel,
  input  logic [r5p_mon_pkg::DW-1:0]   rdt,
  input  logic                         ack,
  // completed transfers
  output logic                         wr_vld,    // write handshake last cycle
  output logic [r5p_mon_pkg::SW-1:0]   wr_sel,    // its byte select
  output logic                         rd_vld,    // read handshake last cycle
  output logic [r5p_mon_pkg::DW-1:0]   rd_dat,    // its data
  output logic                         wait_vld   // wait cycle last cycle
);

  ////////////////////////////////////////
  // delayed bus
  ////////////////////////////////////////

  logic                       req_r;
  logic                       ack_r;
  logic                       wen_r;
  logic [r5p_mon_pkg::SW-1:0] sel_r;
  logic [r5p_mon_pkg::AW-1:0] adr_r;  // observed by the bound checks only

  // handshake state
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      req_r <= 1'b0;
      ack_r <= 1'b0;
    end else begin
      req_r <= req;
      ack_r <= ack;
    end
  end

  // transfer attributes, qualified by req_r/ack_r
  always_ff @(posedge clk) begin
    wen_r <= wen;
    sel_r <= sel;
    adr_r <= adr;
  end

  ////////////////////////////////////////
  // strobes
  ////////////////////////////////////////

  assign wr_vld   = req_r & ack_r &  wen_r;
  assign rd_vld   = req_r & ack_r & ~wen_r;
  assign wait_vld = req_r & ~ack_r;  // one per stalled cycle

  assign wr_sel = sel_r;
  assign rd_dat = rdt;  // memory drives it in this cycle

endmodule

//--- rtl/r5p_bus_mem.sv
/*
  word addressed bus memory, byte select writes
  registered read data, one wait state for the slow half
*/

`timescale 1ns/100ps

module r5p_bus_mem (
  // system
  input  logic                         clk,
  input  logic                         rst,
  // system bus
  input  logic                         req,  // request
  input  logic                         wen,  // write enable
  input  logic [r5p_mon_pkg::AW-1:0]   adr,  // byte address
  input  logic [r5p_mon_pkg::SW-1:0]   sel,  // byte select
  input  logic [r5p_mon_pkg::DW-1:0]   wdt,  // write data
  output logic [r5p_mon_pkg::DW-1:0]   rdt,  // read data, cycle after ack
  output logic                         ack   // acknowledge
);

  ////////////////////////////////////////
  // local signals
  ////////////////////////////////////////

  logic [r5p_mon_pkg::DW-1:0]     mem [2**r5p_mon_pkg::MEM_AW];  // word array
  logic [r5p_mon_pkg::MEM_AW-1:0] word_adr;  // drop byte offset
  logic                           slow;      // request in upper half
  logic                           wait_q;    // wait cycle already spent
  logic                           hs;        // handshake

  assign word_adr = adr[r5p_mon_pkg::MEM_AW+1:2];
  assign slow     = adr[r5p_mon_pkg::SLOW_BIT];

  ////////////////////////////////////////
  // wait state
  ////////////////////////////////////////

  // fast half acks at once, slow half after one spent cycle
  assign ack = req & (~slow | wait_q);
  assign hs  = req & ack;

  // set during the low-ack cycle, cleared by the handshake
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= req & slow & ~ack;
    end
  end

  ////////////////////////////////////////
  // array access
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (hs & wen) begin
      // merge only the selected byte lanes
      for (int i = 0; i < r5p_mon_pkg::SW; i++) begin
        if (sel[i]) begin
          mem[word_adr][8*i +: 8] <= wdt[8*i +: 8];
        end
      end
    end
    if (hs & ~wen) begin
      rdt <= mem[word_adr];  // full word, sel ignored on reads
    end
  end

endmodule

//--- rtl/r5p_bus_stats.sv
/*
  bus statistic counters and indexed readout
*/

`timescale 1ns/100ps

module r5p_bus_stats (
  // system
  input  logic                         clk,
  input  logic                         rst,
  // transfer events
  input  logic                         wr_vld,
  input  logic [r5p_mon_pkg::SW-1:0]   wr_sel,
  input  logic                         rd_vld,
  input  logic                         wait_vld,
  // decode events
  input  logic                         cls_vld,
  input  logic [2:0]                   cls,
  input  logic                         neg_imm,
  // readout
  input  logic [3:0]                   stat_idx,
  output logic [r5p_mon_pkg::CW-1:0]   stat_cnt
);

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // number of selected byte lanes
  function automatic logic [r5p_mon_pkg::CW-1:0] pop_cnt(
    input logic [r5p_mon_pkg::SW-1:0] s
  );
    logic [r5p_mon_pkg::CW-1:0] n;
    n = '0;
    for (int i = 0; i < r5p_mon_pkg::SW; i++) begin
      if (s[i]) n++;
    end
    return n;
  endfunction

  // class to counter index
  function automatic logic [3:0] cls_idx(input logic [2:0] c);
    case (c)
      r5p_mon_pkg::CLS_LOAD:   return r5p_mon_pkg::STAT_LOAD;
      r5p_mon_pkg::CLS_STORE:  return r5p_mon_pkg::STAT_STORE;
      r5p_mon_pkg::CLS_BRANCH: return r5p_mon_pkg::STAT_BRANCH;
      r5p_mon_pkg::CLS_JUMP:   return r5p_mon_pkg::STAT_JUMP;
      r5p_mon_pkg::CLS_ALU:    return r5p_mon_pkg::STAT_ALU;
      r5p_mon_pkg::CLS_SYSTEM: return r5p_mon_pkg::STAT_SYSTEM;
      default:                 return r5p_mon_pkg::STAT_OTHER;
    endcase
  endfunction

  ////////////////////////////////////////
  // execute, counter update
  ////////////////////////////////////////

  logic [r5p_mon_pkg::CW-1:0]       cnt [r5p_mon_pkg::STAT_NUM];
  logic [r5p_mon_pkg::STAT_NUM-1:0] hit;       // unit increments this cycle
  logic [r5p_mon_pkg::CW-1:0]       wr_bytes;

  assign wr_bytes = pop_cnt(wr_sel);

  always_comb begin
    hit = '0;
    hit[r5p_mon_pkg::STAT_WRITES] = wr_vld;
    hit[r5p_mon_pkg::STAT_READS]  = rd_vld;
    hit[r5p_mon_pkg::STAT_WAITS]  = wait_vld;
    if (cls_vld) begin
      hit[cls_idx(cls)]             = 1'b1;
      hit[r5p_mon_pkg::STAT_NEGIMM] = neg_imm;
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 0; i < r5p_mon_pkg::STAT_NUM; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < r5p_mon_pkg::STAT_NUM; i++) begin
        if (i == r5p_mon_pkg::STAT_WBYTES) begin
          if (wr_vld) cnt[i] <= cnt[i] + wr_bytes;  // byte count, not unit
        end else if (hit[i]) begin
          cnt[i] <= cnt[i] + 1'b1;  // wraps
        end
      end
    end
  end

  ////////////////////////////////////////
  // result, readout mux
  ////////////////////////////////////////

  assign stat_cnt = (stat_idx < r5p_mon_pkg::STAT_NUM) ? cnt[stat_idx] : '0;

endmodule

//--- rtl/r5p_inst_decode.sv
/*
  instruction classifier for read data words
  class and negative I-immediate flag, one register stage
*/

`timescale 1ns/100ps

module r5p_inst_decode (
  // system
  input  logic                         clk,
  input  logic                         rst,
  // from capture
  input  logic                         rd_vld,
  input  logic [r5p_mon_pkg::DW-1:0]   rd_dat,
  // to statistics
  output logic                         cls_vld,  // one cycle after rd_vld
  output logic [2:0]                   cls,      // instruction class
  output logic                         neg_imm   // I-format, imm12 negative
);

  ////////////////////////////////////////
  // local signals
  ////////////////////////////////////////

  r5p_mon_pkg::inst_u inst;     // word viewed as R and I fields
  logic [2:0]         cls_nxt;  // class of the current word
  logic               imm_fmt;  // carries an I-format immediate
  logic               neg_nxt;

  assign inst = rd_dat;

  ////////////////////////////////////////
  // classification
  ////////////////////////////////////////

  // opcode literals all end in 2'b11, so compressed words fall to default
  always_comb begin
    cls_nxt = r5p_mon_pkg::CLS_OTHER;
    imm_fmt = 1'b0;
    case (inst.r.opcode)
      r5p_mon_pkg::OPC_LOAD: begin
        cls_nxt = r5p_mon_pkg::CLS_LOAD;
        imm_fmt = 1'b1;
      end
      r5p_mon_pkg::OPC_STORE:  cls_nxt = r5p_mon_pkg::CLS_STORE;
      r5p_mon_pkg::OPC_BRANCH: cls_nxt = r5p_mon_pkg::CLS_BRANCH;
      r5p_mon_pkg::OPC_JAL:    cls_nxt = r5p_mon_pkg::CLS_JUMP;
      r5p_mon_pkg::OPC_JALR: begin
        cls_nxt = r5p_mon_pkg::CLS_JUMP;
        imm_fmt = 1'b1;  // jalr offset
      end
      r5p_mon_pkg::OPC_OP,
      r5p_mon_pkg::OPC_LUI,
      r5p_mon_pkg::OPC_AUIPC:  cls_nxt = r5p_mon_pkg::CLS_ALU;
      r5p_mon_pkg::OPC_OP_IMM: begin
        cls_nxt = r5p_mon_pkg::CLS_ALU;
        imm_fmt = 1'b1;
      end
      r5p_mon_pkg::OPC_SYSTEM: cls_nxt = r5p_mon_pkg::CLS_SYSTEM;
      default:                 cls_nxt = r5p_mon_pkg::CLS_OTHER;
    endcase
  end

  // sign of imm12 read through the I view
  assign neg_nxt = imm_fmt & inst.i.imm12[11];

  ////////////////////////////////////////
  // output stage
  ////////////////////////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      cls_vld <= 1'b0;
    end else begin
      cls_vld <= rd_vld;
    end
  end

  // class payload, held between reads
  always_ff @(posedge clk) begin
    if (rd_vld) begin
      cls     <= cls_nxt;
      neg_imm <= neg_nxt;
    end
  end

endmodule

//--- rtl/r5p_mon_pkg.sv
/*
  shared constants for the r5p bus observer
  bus widths, memory size, opcodes, classes, statistic indices, instruction union
*/

package r5p_mon_pkg;

  ////////////////////////////////////////
  // bus and memory
  ////////////////////////////////////////

  localparam int unsigned AW       = 32;    // address width
  localparam int unsigned DW       = 32;    // data width
  localparam int unsigned SW       = DW/8;  // byte select width
  localparam int unsigned MEM_AW   = 8;     // word address bits, adr[9:2]
  localparam int unsigned SLOW_BIT = 9;     // upper half gets a wait state

  ////////////////////////////////////////
  // RV32I major opcodes
  ////////////////////////////////////////

  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // instruction classes
  localparam logic [2:0] CLS_LOAD   = 3'd0;
  localparam logic [2:0] CLS_STORE  = 3'd1;
  localparam logic [2:0] CLS_BRANCH = 3'd2;
  localparam logic [2:0] CLS_JUMP   = 3'd3;  // jal, jalr
  localparam logic [2:0] CLS_ALU    = 3'd4;  // op, op-imm, lui, auipc
  localparam logic [2:0] CLS_SYSTEM = 3'd5;
  localparam logic [2:0] CLS_OTHER  = 3'd6;  // anything else, incl. 16-bit words

  ////////////////////////////////////////
  // statistic counters
  ////////////////////////////////////////

  localparam logic [3:0] STAT_WRITES = 4'd0;
  localparam logic [3:0] STAT_READS  = 4'd1;
  localparam logic [3:0] STAT_WBYTES = 4'd2;   // selected bytes written
  localparam logic [3:0] STAT_WAITS  = 4'd3;   // req high, ack low cycles
  localparam logic [3:0] STAT_LOAD   = 4'd4;
  localparam logic [3:0] STAT_STORE  = 4'd5;
  localparam logic [3:0] STAT_BRANCH = 4'd6;
  localparam logic [3:0] STAT_JUMP   = 4'd7;
  localparam logic [3:0] STAT_ALU    = 4'd8;
  localparam logic [3:0] STAT_SYSTEM = 4'd9;
  localparam logic [3:0] STAT_OTHER  = 4'd10;
  localparam logic [3:0] STAT_NEGIMM = 4'd11;  // I-format with imm12 < 0
  localparam int unsigned STAT_NUM   = 12;

  localparam int unsigned CW = 32;  // counter width, wraps

  // one instruction word, R and I field views
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;  // sign in bit 11
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } inst_u;

endpackage

//--- rtl/r5p_mon_top.sv
/*
  bus observer top, memory with capture, decode and statistics
*/

`timescale 1ns/100ps

module r5p_mon_top (
  // system
  input  logic                         clk,
  input  logic                         rst,
  // system bus from master
  input  logic                         req,
  input  logic                         wen,
  input  logic [r5p_mon_pkg::AW-1:0]   adr,
  input  logic [r5p_mon_pkg::SW-1:0]   sel,
  input  logic [r5p_mon_pkg::DW-1:0]   wdt,
  output logic [r5p_mon_pkg::DW-1:0]   rdt,
  output logic                         ack,
  // statistics readout
  input  logic [3:0]                   stat_idx,
  output logic [r5p_mon_pkg::CW-1:0]   stat_cnt
);

  ////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////

  logic                       wr_vld;
  logic [r5p_mon_pkg::SW-1:0] wr_sel;
  logic                       rd_vld;
  logic [r5p_mon_pkg::DW-1:0] rd_dat;
  logic                       wait_vld;
  logic                       cls_vld;
  logic [2:0]                 cls;
  logic                       neg_imm;

  // bus slave
  r5p_bus_mem mem (
    .clk (clk),  .rst (rst),
    .req (req),  .wen (wen),  .adr (adr),  .sel (sel),  .wdt (wdt),
    .rdt (rdt),  .ack (ack)
  );

  // taps on the same bus wires
  r5p_bus_capture capture (
    .clk      (clk),     .rst    (rst),
    .req      (req),     .wen    (wen),    .adr (adr),  .sel (sel),
    .rdt      (rdt),     .ack    (ack),
    .wr_vld   (wr_vld),  .wr_sel (wr_sel),
    .rd_vld   (rd_vld),  .rd_dat (rd_dat),
    .wait_vld (wait_vld)
  );

  // read data as instructions
  r5p_inst_decode decode (
    .clk     (clk),      .rst    (rst),
    .rd_vld  (rd_vld),   .rd_dat (rd_dat),
    .cls_vld (cls_vld),  .cls    (cls),    .neg_imm (neg_imm)
  );

  r5p_bus_stats stats (
    .clk      (clk),       .rst      (rst),
    .wr_vld   (wr_vld),    .wr_sel   (wr_sel),
    .rd_vld   (rd_vld),    .wait_vld (wait_vld),
    .cls_vld  (cls_vld),   .cls      (cls),     .neg_imm (neg_imm),
    .stat_idx (stat_idx),  .stat_cnt (stat_cnt)
  );

endmodule

//--- tests/r5p_mon_asserts.sv
/*
  concurrent bus and pipeline checks, bound into the bus capture
*/

`timescale 1ns/100ps

module r5p_mon_asserts (
  input logic                       clk,
  input logic                       rst,
  input logic                       req,
  input logic                       wen,
  input logic [r5p_mon_pkg::AW-1:0] adr,
  input logic [r5p_mon_pkg::SW-1:0] sel,
  input logic                       ack,
  input logic                       req_r,  // delayed copies from capture
  input logic                       ack_r,
  input logic                       wen_r,
  input logic [r5p_mon_pkg::SW-1:0] sel_r,
  input logic [r5p_mon_pkg::AW-1:0] adr_r,
  input logic                       wr_vld,
  input logic                       rd_vld,
  input logic                       cls_vld  // from decode
);

  ////////////////////////////////////////
  // bus protocol
  ////////////////////////////////////////

  a_ack_req: assert property (@(posedge clk) disable iff (rst) ack |-> req)
    else $error("ack seen while req is low");

  // last cycle stalled, so the request must be unchanged now
  a_hold: assert property (@(posedge clk) disable iff (rst)
    (req_r && !ack_r) |-> (req && adr == adr_r && wen == wen_r && sel == sel_r))
    else $error("request changed during a wait cycle");

  ////////////////////////////////////////
  // monitor pipeline
  ////////////////////////////////////////

  a_excl: assert property (@(posedge clk) disable iff (rst) !(rd_vld && wr_vld))
    else $error("read and write completion in the same cycle");

  a_cls_next: assert property (@(posedge clk) disable iff (rst) rd_vld |=> cls_vld)
    else $error("no class strobe after a read");

  a_cls_only: assert property (@(posedge clk) disable iff (rst) cls_vld |-> $past(rd_vld))
    else $error("class strobe without a read before it");

endmodule

// decode sits next to capture in the top, reached upward
bind r5p_bus_capture r5p_mon_asserts chk (
  .clk (clk), .rst (rst), .req (req), .wen (wen), .adr (adr), .sel (sel), .ack (ack),
  .req_r (req_r), .ack_r (ack_r), .wen_r (wen_r), .sel_r (sel_r), .adr_r (adr_r),
  .wr_vld (wr_vld), .rd_vld (rd_vld), .cls_vld (decode.cls_vld)
);

//--- tests/r5p_mon_tb.sv
/*
  testbench for the bus observer top, xorshift traffic
  memory and statistics model, compare task, verdict
*/

`timescale 1ns/100ps

module r5p_mon_tb;

  localparam int ACK_TMO = 8;  // cycles before giving up on ack

  logic        clk;
  logic        rst;
  logic        req;
  logic        wen;
  logic [31:0] adr;
  logic [3:0]  sel;
  logic [31:0] wdt;
  logic [3:0]  stat_idx;
  logic [31:0] rdt;
  logic        ack;
  logic [31:0] stat_cnt;

  logic [31:0] mem_m [256];   // model memory
  int unsigned exp_cnt [16];  // model counters by stat index
  logic [31:0] rng = 32'hf2b9;
  logic [6:0]  opc_list [10];

  r5p_mon_top uut (
    .clk (clk), .rst (rst), .req (req), .wen (wen), .adr (adr), .sel (sel),
    .wdt (wdt), .rdt (rdt), .ack (ack), .stat_idx (stat_idx), .stat_cnt (stat_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // counter index from the opcode rule
  function automatic int stat_of(input logic [31:0] w);
    case (w[6:0])
      r5p_mon_pkg::OPC_LOAD:   return r5p_mon_pkg::STAT_LOAD;
      r5p_mon_pkg::OPC_STORE:  return r5p_mon_pkg::STAT_STORE;
      r5p_mon_pkg::OPC_BRANCH: return r5p_mon_pkg::STAT_BRANCH;
      r5p_mon_pkg::OPC_JAL, r5p_mon_pkg::OPC_JALR: return r5p_mon_pkg::STAT_JUMP;
      r5p_mon_pkg::OPC_OP, r5p_mon_pkg::OPC_OP_IMM,
      r5p_mon_pkg::OPC_LUI, r5p_mon_pkg::OPC_AUIPC: return r5p_mon_pkg::STAT_ALU;
      r5p_mon_pkg::OPC_SYSTEM: return r5p_mon_pkg::STAT_SYSTEM;
      default:                 return r5p_mon_pkg::STAT_OTHER;
    endcase
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////
  // bus master with model update
  ////////////////////////////////////////

  // entered 10 ns after a rising edge, leaves the same way
  task automatic bus_xfer(input logic we, input logic [31:0] a, input logic [3:0] s,
                          input logic [31:0] d);
    int         waits;
    logic [7:0] w;
    logic [6:0] opc;
    waits = 0;
    w     = a[9:2];
    req   = 1'b1;
    wen   = we;
    adr   = a;
    sel   = s;
    wdt   = d;
    @(negedge clk);  // ack settled mid cycle
    while (ack !== 1'b1) begin
      waits++;
      if (waits > ACK_TMO) stop_run($sformatf("no ack after %0d cycles at %h", waits, a));
      @(negedge clk);
    end
    check_eq("wait_cycles", a[r5p_mon_pkg::SLOW_BIT], waits);
    @(posedge clk);  // handshake edge
    #10;
    req = 1'b0;
    check_eq("stat_15", 32'h0, stat_cnt);  // idx 15 parked during traffic
    exp_cnt[r5p_mon_pkg::STAT_WAITS] += waits;
    if (we) begin
      exp_cnt[r5p_mon_pkg::STAT_WRITES]++;
      for (int i = 0; i < 4; i++) begin
        if (s[i]) begin
          mem_m[w][8*i +: 8] = d[8*i +: 8];  // selected lanes only
          exp_cnt[r5p_mon_pkg::STAT_WBYTES]++;
        end
      end
    end else begin
      check_eq("read_data", mem_m[w], rdt);  // rdt valid in T+1
      exp_cnt[r5p_mon_pkg::STAT_READS]++;
      exp_cnt[stat_of(mem_m[w])]++;
      opc = mem_m[w][6:0];
      if ((opc == r5p_mon_pkg::OPC_LOAD || opc == r5p_mon_pkg::OPC_JALR ||
           opc == r5p_mon_pkg::OPC_OP_IMM) && mem_m[w][31]) begin
        exp_cnt[r5p_mon_pkg::STAT_NEGIMM]++;
      end
    end
  endtask

  // idle cycles so decode and counters catch up
  task automatic drain();
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
    end
    #10;
  endtask

  // all 16 indices, 12..15 stay zero in the model
  task automatic check_stats(input string tag);
    for (int i = 0; i < 16; i++) begin
      stat_idx = i;
      #1;
      check_eq($sformatf("%s stat %0d", tag, i), exp_cnt[i], stat_cnt);
    end
    stat_idx = 4'd15;
    @(posedge clk);
    #10;
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] d;
    logic [31:0] r;
    rst      = 1'b1;
    req      = 1'b0;
    wen      = 1'b0;
    adr      = '0;
    sel      = '0;
    wdt      = '0;
    stat_idx = 4'd15;
    opc_list = '{r5p_mon_pkg::OPC_LOAD, r5p_mon_pkg::OPC_STORE, r5p_mon_pkg::OPC_BRANCH,
                 r5p_mon_pkg::OPC_JAL, r5p_mon_pkg::OPC_JALR, r5p_mon_pkg::OPC_OP,
                 r5p_mon_pkg::OPC_OP_IMM, r5p_mon_pkg::OPC_LUI, r5p_mon_pkg::OPC_AUIPC,
                 r5p_mon_pkg::OPC_SYSTEM};
    for (int i = 0; i < 16; i++) exp_cnt[i] = 0;
    repeat (5) @(posedge clk);
    #10;
    rst = 1'b0;
    check_stats("reset");

    // preload every word, most of them forced to a real opcode
    for (int k = 0; k < 256; k++) begin
      d = xorshift();
      if (k % 4 != 0) d[6:0] = opc_list[k % 10];
      bus_xfer(1'b1, k << 2, 4'hf, d);
    end

    // mixed traffic with random byte selects
    for (int n = 0; n < 400; n++) begin
      r = xorshift();
      d = xorshift();
      bus_xfer(r[0], xorshift() & 32'h3fc, r[7:4], d);
    end

    // full read back for the class counters
    for (int k = 0; k < 256; k++) begin
      bus_xfer(1'b0, k << 2, 4'hf, 32'h0);
    end
    drain();
    check_stats("final");

    $display("Test completed successfully");
    $finish;
  end

endmodule
